// File: build.f
+incdir+tb
rtl/cpu_pkg.sv
rtl/pipe_reg.sv
rtl/register_file.sv
rtl/alu.sv
rtl/forwarding_unit.sv
rtl/hazard_unit.sv
rtl/branch_unit.sv
rtl/cpu.sv
tb/tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
# Build the pipelined core testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module tb_cpu -f build.f -o tb_cpu_sim

# tee keeps the pipeline status at zero, the log decides the result
./obj_dir/tb_cpu_sim 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation PASSED"

// File: tb/isa_model.svh
localparam int PROG_LEN = 60;  // Random part
localparam int EPI_LEN  = 19;  // Register dump and HLT

logic [15:0] mreg [16];
logic [15:0] mdl_mem [65536];
flags_t      mflags;
logic [15:0] halt_pc;
logic [15:0] exp_addr [$];
logic [15:0] exp_data [$];
logic [15:0] exp_load [$];

function automatic logic [15:0] fill_word(input logic [15:0] a);
  return {a[7:0], a[15:8]} ^ (a << 3) ^ 16'ha5c3;
endfunction

function automatic logic [15:0] rand_single(input int i, input int mode);
  logic [3:0] rd;
  logic [3:0] rs;
  logic [3:0] rt;
  int         pick;
  int         lim;
  rd   = 4'($urandom_range(14, 0));
  rs   = 4'($urandom_range(14, 0));
  rt   = 4'($urandom_range(14, 0));
  pick = $urandom_range(11, 0);
  if (mode == 2 && pick > 8) pick = 11;  // Branch heavy
  lim  = (PROG_LEN - 1 - i) < 4 ? (PROG_LEN - 1 - i) : 4;
  case (pick)
    0, 1, 2: return {4'(pick), rd, rs, rt};      // ADD SUB XOR
    3, 4, 5: return {4'(pick + 1), rd, rs, rt};  // SLL SRA ROR
    6:       return {OP_LW, rd, rs, rt};
    7:       return {OP_SW, rd, rs, rt};
    8:       return {OP_LLB, rd, 8'($urandom)};
    9:       return {OP_LHB, rd, 8'($urandom)};
    10:      return {OP_PCS, rd, 8'h00};
    default: return {OP_B, 3'($urandom), 9'($urandom_range(lim, 0))};  // Forward only
  endcase
endfunction

// A branch in the last four slots could land inside a BR triple at slot i
function automatic logic branch_nearby(input int i);
  logic hit;
  hit = 1'b0;
  for (int j = (i > 4) ? i - 4 : 0; j < i; j++) begin
    if (imem[j][15:12] == OP_B || imem[j][15:12] == OP_BR) hit = 1'b1;
  end
  return hit;
endfunction

task automatic gen_program(input int mode);
  int          i;
  int          k;
  logic [3:0]  rd;
  logic [15:0] tgt;
  for (int a = 0; a < 256; a++) imem[a] = {OP_HLT, 12'h000};
  i = 0;
  while (i < PROG_LEN) begin
    rd = 4'($urandom_range(14, 1));
    if (mode == 1 && $urandom_range(1, 0) == 1 && i < PROG_LEN - 1) begin
      imem[i] = {OP_LW, rd, 4'($urandom_range(14, 0)), 4'($urandom)};
      if ($urandom_range(1, 0) == 1)
        imem[i+1] = {OP_SW, rd, 4'($urandom_range(14, 0)), 4'($urandom)};
      else
        imem[i+1] = {4'($urandom_range(2, 0)), 4'($urandom_range(14, 0)), rd,
                     4'($urandom_range(14, 0))};
      i += 2;
    end else if (mode == 2 && $urandom_range(3, 0) == 0 && i < PROG_LEN - 3 &&
                 !branch_nearby(i)) begin
      // Build a forward address in rd, then BR on it
      k   = $urandom_range((PROG_LEN - 3 - i) < 3 ? (PROG_LEN - 3 - i) : 3, 0);
      tgt = 16'(2 * (i + 3 + k));
      imem[i]   = {OP_LLB, rd, tgt[7:0]};
      imem[i+1] = {OP_LHB, rd, tgt[15:8]};
      imem[i+2] = {OP_BR, 3'($urandom), 1'b0, rd, 4'h0};
      i += 3;
    end else begin
      imem[i] = rand_single(i, mode);
      i++;
    end
  end
  // R15 becomes the dump base at 0x0100, then 0x010E
  imem[60] = {OP_LHB, 4'd15, 8'h01};
  imem[61] = {OP_LLB, 4'd15, 8'h00};
  for (int r = 1; r <= 7; r++) imem[61+r] = {OP_SW, 4'(r), 4'd15, 4'(r - 1)};
  imem[69] = {OP_LLB, 4'd15, 8'h0E};
  for (int r = 8; r <= 14; r++) imem[62+r] = {OP_SW, 4'(r), 4'd15, 4'(r - 8)};
  imem[77] = {OP_SW, 4'd15, 4'd15, 4'd7};
  imem[78] = {OP_HLT, 12'h000};
endtask

function automatic logic cond_met(input logic [2:0] c);
  case (c)
    3'd0:    return !mflags.z;
    3'd1:    return mflags.z;
    3'd2:    return !mflags.z && !mflags.n;
    3'd3:    return mflags.n;
    3'd4:    return mflags.z || !mflags.n;
    3'd5:    return mflags.z || mflags.n;
    3'd6:    return mflags.v;
    default: return 1'b1;
  endcase
endfunction

task automatic write_reg(input logic [3:0] d, input logic [15:0] v);
  if (d != 4'd0) mreg[d] = v;  // R0 stays zero
endtask

// One instruction per step, in program order
task automatic run_model();
  logic [15:0] pc;
  logic [15:0] ins;
  logic [15:0] a;
  logic [15:0] b;
  logic [15:0] res;
  logic [15:0] addr;
  logic [15:0] off;
  logic        ovf;
  logic        done;
  int          steps;
  for (int r = 0; r < 16; r++) mreg[r] = 16'h0000;
  for (int m = 0; m < 65536; m++) mdl_mem[m] = fill_word(16'(m));
  mflags = '0;
  exp_addr.delete();
  exp_data.delete();
  exp_load.delete();
  pc    = 16'h0000;
  done  = 1'b0;
  steps = 0;
  while (!done) begin
    ins  = imem[pc[8:1]];
    a    = mreg[ins[7:4]];
    b    = mreg[ins[3:0]];
    off  = {{11{ins[3]}}, ins[3:0], 1'b0};
    addr = a + off;
    pc   = pc + 16'd2;  // PC+2 from here on
    case (opcode_t'(ins[15:12]))
      OP_ADD, OP_SUB: begin
        res = ins[12] ? a - b : a + b;
        ovf = ins[12] ? (a[15] != b[15] && res[15] != a[15])
                      : (a[15] == b[15] && res[15] != a[15]);
        if (ovf) res = a[15] ? 16'h8000 : 16'h7fff;  // Saturate
        write_reg(ins[11:8], res);
        mflags = '{z: res == 16'h0000, v: ovf, n: res[15]};
      end
      OP_XOR, OP_SLL, OP_SRA, OP_ROR: begin
        case (opcode_t'(ins[15:12]))
          OP_XOR:  res = a ^ b;
          OP_SLL:  res = a << ins[3:0];
          OP_SRA:  res = $signed(a) >>> ins[3:0];
          default: res = (a >> ins[3:0]) | (a << (5'd16 - {1'b0, ins[3:0]}));
        endcase
        write_reg(ins[11:8], res);
        mflags.z = (res == 16'h0000);
      end
      OP_LW: begin
        write_reg(ins[11:8], mdl_mem[addr]);
        exp_load.push_back(addr);
      end
      OP_SW: begin
        mdl_mem[addr] = mreg[ins[11:8]];
        exp_addr.push_back(addr);
        exp_data.push_back(mreg[ins[11:8]]);
      end
      OP_LLB: write_reg(ins[11:8], {mreg[ins[11:8]][15:8], ins[7:0]});
      OP_LHB: write_reg(ins[11:8], {ins[7:0], mreg[ins[11:8]][7:0]});
      OP_B:   if (cond_met(ins[11:9])) pc = pc + {{6{ins[8]}}, ins[8:0], 1'b0};
      OP_BR:  if (cond_met(ins[11:9])) pc = a;
      OP_PCS: write_reg(ins[11:8], pc);
      OP_HLT: begin
        halt_pc = pc - 16'd2;
        done    = 1'b1;
      end
      default: fail_now("ERROR: model reached an undefined opcode");
    endcase
    steps++;
    if (steps > 1000) fail_now("ERROR: model program never reached HLT");
  end
endtask

// File: tb/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu import cpu_pkg::*; ();

  localparam int          DATA_W    = 16;
  localparam int          NUM_PROGS = 10;
  localparam logic [31:0] SEED      = 32'ha26cf32d;

  logic        clk;
  logic        reset;
  logic        fill_req;
  logic [15:0] imem_addr;
  logic [15:0] imem_data;
  logic [15:0] dmem_addr;
  logic [15:0] dmem_wdata;
  logic [15:0] dmem_rdata;
  logic [15:0] pc_out;
  logic        dmem_we;
  logic        dmem_re;
  logic        hlt;
  logic [15:0] imem [256];
  logic [15:0] dmem [65536];
  int          cycles = 0;
  int          store_idx;
  int          load_idx;

  `include "isa_model.svh"

  // Worst case four cycles per instruction plus reset and halt checks
  localparam int MAX_CYCLES = NUM_PROGS * ((PROG_LEN + EPI_LEN) * 4 + 12);

  cpu #(.DATA_W(DATA_W)) i_cpu (
    .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we), .dmem_re(dmem_re),
    .dmem_rdata(dmem_rdata), .hlt(hlt), .pc_out(pc_out)
  );

  ////////////////////////////////////////
  // Clock and memories
  ////////////////////////////////////////
  initial clk = 1'b0;
  always #20 clk = ~clk;

  assign imem_data  = imem[imem_addr[8:1]];
  assign dmem_rdata = dmem[dmem_addr];  // Same-cycle read

  // No load sits in MEM while a store writes
  always @(posedge clk) begin
    if (fill_req) begin
      for (int a = 0; a < 65536; a++) dmem[a] = fill_word(16'(a));
    end else if (dmem_we) begin
      dmem[dmem_addr] = dmem_wdata;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [15:0] expected,
                       input logic [15:0] actual);
    if (expected !== actual)
      fail_now($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
  endtask

  // Store and load streams against the model, in order
  always @(negedge clk) begin
    if (reset) begin
      store_idx = 0;
      load_idx  = 0;
    end else begin
      if (dmem_we) begin
        if (store_idx >= exp_addr.size()) begin
          fail_now("ERROR: core stored more values than the model");
        end else begin
          check("store address", exp_addr[store_idx], dmem_addr);
          check("store data", exp_data[store_idx], dmem_wdata);
          store_idx++;
        end
      end
      if (dmem_re) begin
        if (load_idx >= exp_load.size()) begin
          fail_now("ERROR: core loaded more values than the model");
        end else begin
          check("load address", exp_load[load_idx], dmem_addr);
          load_idx++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES)
      fail_now($sformatf("ERROR: core never halted within %0d cycles", MAX_CYCLES));
  end

  ////////////////////////////////////////
  // Programs
  ////////////////////////////////////////
  initial begin
    reset    = 1'b1;
    fill_req = 1'b0;
    void'($urandom(SEED));
    for (int p = 0; p < NUM_PROGS; p++) begin
      gen_program(p % 3);  // Mixed, load-use, branches
      run_model();
      @(posedge clk);
      #2;
      reset    = 1'b1;
      fill_req = 1'b1;
      @(posedge clk);
      #2;
      fill_req = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk);
      check("hlt after reset", 16'd0, {15'd0, hlt});
      while (!hlt) @(negedge clk);
      check("halt pc", halt_pc, pc_out);
      check("store count", 16'(exp_addr.size()), 16'(store_idx));
      check("load count", 16'(exp_load.size()), 16'(load_idx));
      repeat (3) begin
        @(negedge clk);
        check("hlt held", 16'd1, {15'd0, hlt});
        check("dmem_we after halt", 16'd0, {15'd0, dmem_we});
        check("dmem_re after halt", 16'd0, {15'd0, dmem_re});
        check("pc after halt", halt_pc, pc_out);
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: rtl/cpu.sv
`timescale 1ns/1ns

module cpu import cpu_pkg::*; #(
  parameter int DATA_W = 16
) (
  input  logic              clk,
  input  logic              reset,
  output logic [DATA_W-1:0] imem_addr,
  input  logic [DATA_W-1:0] imem_data,
  output logic [DATA_W-1:0] dmem_addr,
  output logic [DATA_W-1:0] dmem_wdata,
  output logic              dmem_we,
  output logic              dmem_re,
  input  logic [DATA_W-1:0] dmem_rdata,
  output logic              hlt,
  output logic [DATA_W-1:0] pc_out
);

  logic [DATA_W-1:0] pc, pc_plus_2, branch_target, br_val;
  logic [DATA_W-1:0] rf_rd1, rf_rd2, wb_data, dec_imm;
  logic [DATA_W-1:0] ex_a, ex_b, ex_store, mem_store, alu_result;
  logic [15:0]       dec_instr;
  logic [3:0]        dec_src1, dec_src2;
  logic [1:0]        halt_sr;
  logic              dec_valid, dec_hlt, frozen;
  logic              stall, take_branch, redirect;
  opcode_t           dec_op;
  ctrl_t             dec_ctrl;
  flags_t            alu_flags;
  if_id_t            if_id_d, if_id;
  id_ex_t            id_ex_d, id_ex;
  ex_mem_t           ex_mem_d, ex_mem;
  mem_wb_t           mem_wb_d, mem_wb;

  ////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////
  assign pc_plus_2 = pc + DATA_W'(2);
  assign imem_addr = pc;
  assign pc_out    = pc;
  assign if_id_d   = '{instr: imem_data, pc_plus_2: pc_plus_2};
  assign redirect  = take_branch && !stall;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (dec_hlt) begin
      pc <= if_id.pc_plus_2 - DATA_W'(2);  // Park on the HLT
    end else if (!frozen && !stall) begin
      pc <= redirect ? branch_target : pc_plus_2;
    end
  end

  pipe_reg #(.T(if_id_t)) if_id_reg (
    .clk(clk), .reset(reset), .stall(stall), .flush(redirect || dec_hlt || frozen),
    .d(if_id_d), .q(if_id)
  );

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  assign dec_instr = if_id.instr;
  assign dec_op    = opcode_t'(dec_instr[15:12]);
  assign dec_valid = |if_id.pc_plus_2;
  assign dec_hlt   = dec_valid && dec_op == OP_HLT;

  always_comb begin
    dec_ctrl = '0;
    dec_imm  = '0;
    dec_src1 = 4'd0;  // No source means no hazard
    dec_src2 = 4'd0;
    case (dec_op)
      OP_ADD, OP_SUB, OP_XOR: begin
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.sets_z    = 1'b1;
        dec_ctrl.sets_vn   = (dec_op != OP_XOR);
        dec_src1           = dec_instr[7:4];
        dec_src2           = dec_instr[3:0];
      end
      OP_SLL, OP_SRA, OP_ROR: begin
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.sets_z    = 1'b1;
        dec_ctrl.alu_imm   = 1'b1;
        dec_imm            = {{(DATA_W-4){1'b0}}, dec_instr[3:0]};
        dec_src1           = dec_instr[7:4];
      end
      OP_LW, OP_SW: begin
        dec_ctrl.reg_write = (dec_op == OP_LW);
        dec_ctrl.mem_read  = (dec_op == OP_LW);
        dec_ctrl.mem_write = (dec_op == OP_SW);
        dec_ctrl.alu_imm   = 1'b1;
        dec_imm            = {{(DATA_W-5){dec_instr[3]}}, dec_instr[3:0], 1'b0};
        dec_src1           = dec_instr[7:4];
        dec_src2           = (dec_op == OP_SW) ? dec_instr[11:8] : 4'd0;  // Store data
      end
      OP_LLB, OP_LHB: begin
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.alu_imm   = 1'b1;
        dec_imm            = {{(DATA_W-8){1'b0}}, dec_instr[7:0]};
        dec_src1           = dec_instr[11:8];  // Byte merges into rd
      end
      OP_PCS: begin
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.alu_imm   = 1'b1;  // PC+2 plus zero
      end
      OP_BR:   dec_src1 = dec_instr[7:4];
      default: ;
    endcase
    if (!dec_valid) begin
      dec_ctrl = '0;
    end
  end

  // BR target, ALU result one stage ahead is usable right away
  assign br_val = (ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read && dec_src1 != 4'd0 &&
                   ex_mem.dst == dec_src1) ? ex_mem.result : rf_rd1;
  assign branch_target = (dec_op == OP_BR) ? br_val
                       : if_id.pc_plus_2 + {{(DATA_W-10){dec_instr[8]}}, dec_instr[8:0], 1'b0};

  assign id_ex_d = '{
    ctrl:  dec_ctrl,
    op:    dec_op,
    dst:   dec_instr[11:8],
    src1:  dec_src1,
    src2:  dec_src2,
    rd1:   (dec_op == OP_PCS) ? if_id.pc_plus_2 : rf_rd1,
    rd2:   rf_rd2,
    imm:   dec_imm,
    valid: dec_valid
  };

  register_file #(.DATA_W(DATA_W)) regs (
    .clk(clk), .reset(reset), .src1(dec_src1), .src2(dec_src2),
    .dst(mem_wb.dst), .write(mem_wb.reg_write), .wdata(wb_data),
    .rdata1(rf_rd1), .rdata2(rf_rd2)
  );

  hazard_unit hazards (
    .dec_op(dec_op), .dec_src1(dec_src1), .dec_src2(dec_src2),
    .id_ex(id_ex), .ex_mem(ex_mem), .stall(stall)
  );

  branch_unit branches (
    .clk(clk), .reset(reset), .set_z(id_ex.ctrl.sets_z), .set_vn(id_ex.ctrl.sets_vn),
    .alu_flags(alu_flags), .op(dec_op), .ccc(dec_instr[11:9]), .take_branch(take_branch)
  );

  // Stalled decode leaves a bubble behind it
  pipe_reg #(.T(id_ex_t)) id_ex_reg (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(stall), .d(id_ex_d), .q(id_ex)
  );

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////
  forwarding_unit fwd (
    .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb), .wb_data(wb_data),
    .ex_a(ex_a), .ex_b(ex_b), .ex_store(ex_store), .mem_store(mem_store)
  );

  alu #(.DATA_W(DATA_W)) alu_core (
    .op(id_ex.op), .a(ex_a), .b(ex_b), .result(alu_result), .flags(alu_flags)
  );

  assign ex_mem_d = '{
    ctrl:       id_ex.ctrl,
    dst:        id_ex.dst,
    src2:       id_ex.src2,
    result:     alu_result,
    store_data: ex_store,
    valid:      id_ex.valid
  };

  pipe_reg #(.T(ex_mem_t)) ex_mem_reg (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(ex_mem_d), .q(ex_mem)
  );

  ////////////////////////////////////////
  // Memory and writeback
  ////////////////////////////////////////
  assign dmem_addr  = ex_mem.result;
  assign dmem_wdata = mem_store;
  assign dmem_we    = ex_mem.ctrl.mem_write;
  assign dmem_re    = ex_mem.ctrl.mem_read;

  assign mem_wb_d = '{
    reg_write:  ex_mem.ctrl.reg_write,
    mem_to_reg: ex_mem.ctrl.mem_read,
    dst:        ex_mem.dst,
    result:     ex_mem.result,
    read_data:  dmem_rdata
  };

  pipe_reg #(.T(mem_wb_t)) mem_wb_reg (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(mem_wb_d), .q(mem_wb)
  );

  assign wb_data = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.result;

  // HLT retires three cycles after decode
  always_ff @(posedge clk) begin
    if (reset) begin
      frozen  <= 1'b0;
      halt_sr <= '0;
      hlt     <= 1'b0;
    end else begin
      frozen  <= frozen || dec_hlt;
      halt_sr <= {halt_sr[0], dec_hlt};
      hlt     <= hlt || halt_sr[1];  // Sticky until reset
    end
  end

endmodule

// File: rtl/branch_unit.sv
`timescale 1ns/1ns

module branch_unit import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       set_z,
  input  logic       set_vn,
  input  flags_t     alu_flags,
  input  opcode_t    op,
  input  logic [2:0] ccc,
  output logic       take_branch
);

  flags_t flags;
  logic   cond;

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else begin
      if (set_z) flags.z <= alu_flags.z;
      if (set_vn) begin  // ADD and SUB only
        flags.v <= alu_flags.v;
        flags.n <= alu_flags.n;
      end
    end
  end

  always_comb begin
    case (cond_t'(ccc))
      CC_NE:   cond = !flags.z;
      CC_EQ:   cond = flags.z;
      CC_GT:   cond = !flags.z && !flags.n;
      CC_LT:   cond = flags.n;
      CC_GE:   cond = flags.z || !flags.n;
      CC_LE:   cond = flags.z || flags.n;
      CC_OV:   cond = flags.v;
      default: cond = 1'b1;  // Unconditional
    endcase
  end

  assign take_branch = (op == OP_B || op == OP_BR) && cond;

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit import cpu_pkg::*; (
  input  opcode_t    dec_op,
  input  logic [3:0] dec_src1,
  input  logic [3:0] dec_src2,
  input  id_ex_t     id_ex,
  input  ex_mem_t    ex_mem,
  output logic       stall
);

  logic ex_writes;
  logic is_branch;
  logic load_use;
  logic flag_dep;
  logic br_dep;

  assign ex_writes = id_ex.valid && id_ex.ctrl.reg_write && id_ex.dst != 4'd0;
  assign is_branch = (dec_op == OP_B) || (dec_op == OP_BR);

  // Store data of a SW is caught later by the MEM stage forward
  assign load_use = ex_writes && id_ex.ctrl.mem_read &&
                    (id_ex.dst == dec_src1 ||
                     (id_ex.dst == dec_src2 && dec_op != OP_SW));

  // Flags not yet written by the instruction in EX
  assign flag_dep = is_branch && id_ex.valid && (id_ex.ctrl.sets_z || id_ex.ctrl.sets_vn);

  // BR target register still in flight
  assign br_dep = (dec_op == OP_BR) && dec_src1 != 4'd0 &&
                  ((ex_writes && id_ex.dst == dec_src1) ||
                   (ex_mem.valid && ex_mem.ctrl.mem_read && ex_mem.dst == dec_src1));

  assign stall = load_use || flag_dep || br_dep;

endmodule

// File: rtl/forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit import cpu_pkg::*; (
  input  id_ex_t      id_ex,
  input  ex_mem_t     ex_mem,
  input  mem_wb_t     mem_wb,
  input  logic [15:0] wb_data,
  output logic [15:0] ex_a,
  output logic [15:0] ex_b,
  output logic [15:0] ex_store,
  output logic [15:0] mem_store
);

  // Newest producer first; a load in EX/MEM only has its address yet
  function automatic logic [15:0] pick(input logic [3:0] src, input logic [15:0] reg_val,
                                       input ex_mem_t em, input mem_wb_t mw,
                                       input logic [15:0] wdata);
    logic [15:0] val;
    val = reg_val;
    if (src != 4'd0) begin
      if (em.valid && em.ctrl.reg_write && !em.ctrl.mem_read && em.dst == src) begin
        val = em.result;
      end else if (mw.reg_write && mw.dst == src) begin
        val = wdata;
      end
    end
    return val;
  endfunction

  assign ex_a     = pick(id_ex.src1, id_ex.rd1, ex_mem, mem_wb, wb_data);
  assign ex_store = pick(id_ex.src2, id_ex.rd2, ex_mem, mem_wb, wb_data);
  assign ex_b     = id_ex.ctrl.alu_imm ? id_ex.imm : ex_store;

  // Load right before a store, data arrives one stage late
  assign mem_store = (ex_mem.ctrl.mem_write && mem_wb.reg_write && mem_wb.mem_to_reg &&
                      ex_mem.src2 != 4'd0 && mem_wb.dst == ex_mem.src2)
                   ? wb_data : ex_mem.store_data;

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ns

module alu import cpu_pkg::*; #(
  parameter int DATA_W = 16
) (
  input  opcode_t           op,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  output logic [DATA_W-1:0] result,
  output flags_t            flags
);

  localparam logic [DATA_W-1:0] SAT_MAX = {1'b0, {(DATA_W-1){1'b1}}};
  localparam logic [DATA_W-1:0] SAT_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  logic [DATA_W-1:0]   sum;
  logic [DATA_W-1:0]   diff;
  logic [2*DATA_W-1:0] rot_wide;
  logic [3:0]          shamt;
  logic                add_ovf;
  logic                sub_ovf;
  logic                ovf;

  assign shamt    = b[3:0];
  assign sum      = a + b;
  assign diff     = a - b;
  assign rot_wide = {a, a} >> shamt;

  // Signed overflow, sign of result flips against like-signed inputs
  assign add_ovf = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
  assign sub_ovf = (a[DATA_W-1] != b[DATA_W-1]) && (diff[DATA_W-1] != a[DATA_W-1]);

  always_comb begin
    ovf = 1'b0;
    case (op)
      OP_ADD: begin
        ovf    = add_ovf;
        result = add_ovf ? (a[DATA_W-1] ? SAT_MIN : SAT_MAX) : sum;
      end
      OP_SUB: begin
        ovf    = sub_ovf;
        result = sub_ovf ? (a[DATA_W-1] ? SAT_MIN : SAT_MAX) : diff;
      end
      OP_XOR:               result = a ^ b;
      OP_SLL:               result = a << shamt;
      OP_SRA:               result = $signed(a) >>> shamt;
      OP_ROR:               result = rot_wide[DATA_W-1:0];
      OP_LLB:               result = {a[DATA_W-1:8], b[7:0]};   // Keep high byte
      OP_LHB:               result = {b[7:0], a[DATA_W-9:0]};   // Keep low byte
      OP_LW, OP_SW, OP_PCS: result = sum;  // Address or PC+2
      default:              result = '0;
    endcase
  end

  assign flags.z = (result == '0);
  assign flags.v = ovf;
  assign flags.n = result[DATA_W-1];

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ns

module register_file #(
  parameter int DATA_W = 16
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [3:0]        src1,
  input  logic [3:0]        src2,
  input  logic [3:0]        dst,
  input  logic              write,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata1,
  output logic [DATA_W-1:0] rdata2
);

  logic [DATA_W-1:0] regs [16];
  logic              wr_en;

  assign wr_en = write && dst != 4'd0;  // R0 stays zero

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[dst] <= wdata;
    end
  end

  // Same-cycle write shows through to decode
  assign rdata1 = (src1 == 4'd0) ? '0 : (wr_en && dst == src1) ? wdata : regs[src1];
  assign rdata2 = (src2 == 4'd0) ? '0 : (wr_en && dst == src2) ? wdata : regs[src2];

endmodule

// File: rtl/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic reset,
  input  logic stall,
  input  logic flush,
  input  T     d,
  output T     q
);

  // All-zero payload is a bubble, flush wins over stall
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

// File: rtl/cpu_pkg.sv
package cpu_pkg;

  // Top nibble of every instruction
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_SLL = 4'h4,
    OP_SRA = 4'h5,
    OP_ROR = 4'h6,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_B   = 4'hC,
    OP_BR  = 4'hD,
    OP_PCS = 4'hE,
    OP_HLT = 4'hF
  } opcode_t;

  // Branch condition field, bits 11:9
  typedef enum logic [2:0] {
    CC_NE,
    CC_EQ,
    CC_GT,
    CC_LT,
    CC_GE,
    CC_LE,
    CC_OV,
    CC_ALWAYS
  } cond_t;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  typedef struct packed {
    logic [15:0] instr;
    logic [15:0] pc_plus_2;  // Zero marks a bubble
  } if_id_t;

  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       sets_z;
    logic       sets_vn;
    logic       alu_imm;    // Operand b from imm
    logic [1:0] spare;
  } ctrl_t;

  typedef struct packed {
    ctrl_t       ctrl;
    opcode_t     op;
    logic [3:0]  dst;
    logic [3:0]  src1;
    logic [3:0]  src2;
    logic [15:0] rd1;
    logic [15:0] rd2;
    logic [15:0] imm;
    logic        valid;
  } id_ex_t;

  typedef struct packed {
    ctrl_t       ctrl;
    logic [3:0]  dst;
    logic [3:0]  src2;        // Store data register
    logic [15:0] result;
    logic [15:0] store_data;
    logic        valid;
  } ex_mem_t;

  typedef struct packed {
    logic        reg_write;
    logic        mem_to_reg;
    logic [3:0]  dst;
    logic [15:0] result;
    logic [15:0] read_data;
  } mem_wb_t;

endpackage
